/* design/mpu_pkg.sv */
// MPU shared types
package mpu_pkg;

  ////////////////////
  // Widths and limits
  ////////////////////

  localparam int ADDR_W              = 32;
  localparam int DATA_W              = 32;
  localparam int WORD_ADDR_W         = ADDR_W - 2;
  localparam int NUM_REGIONS_MAX     = 16;
  localparam int MAX_OUTSTANDING_MAX = 7;

  // Bit positions inside the bus memory type
  localparam int MEMTYPE_BUF_BIT   = 0;
  localparam int MEMTYPE_CACHE_BIT = 1;

  ////////////////////
  // Types
  ////////////////////

  typedef enum logic [0:0] {
    MPU_OK    = 1'b0,
    MPU_FAULT = 1'b1
  } mpu_status_e;

  typedef enum logic [1:0] {
    MPU_IDLE     = 2'd0,
    MPU_DRAIN    = 2'd1,
    MPU_ERR_RESP = 2'd2
  } mpu_state_e;

  // One PMA region, bounds are word addresses, high bound is exclusive
  typedef struct packed {
    logic [WORD_ADDR_W-1:0] word_addr_low;
    logic [WORD_ADDR_W-1:0] word_addr_high;
    logic                   main;
    logic                   bufferable;
    logic                   cacheable;
    logic                   lock;
  } pma_region_t;

  // Empty range and I/O attributes
  localparam pma_region_t PMA_DEFAULT_ATTR = '0;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [DATA_W-1:0] wdata;
    logic              instr;
    logic              misaligned;
  } core_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              we;
    logic [DATA_W-1:0] wdata;
    logic [1:0]        memtype;
  } bus_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    mpu_status_e       status;
  } core_resp_t;

  ////////////////////
  // Helpers
  ////////////////////

  // Index width for a table of n entries, at least one bit
  function automatic int idx_w(int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

  function automatic logic pma_contains(pma_region_t r, logic [ADDR_W-1:0] addr);
    return ({r.word_addr_low, 2'b00} <= addr) && (addr < {r.word_addr_high, 2'b00});
  endfunction

endpackage

/* design/pma_region_regs.sv */
// PMA region register bank
`timescale 1ns/1ps

module pma_region_regs import mpu_pkg::*; #(
  parameter int NUM_REGIONS = 4
) (
  input  logic                               clk,
  input  logic                               rst_n,

  // Configuration write port, no handshake
  input  logic                               cfg_we_i,
  input  logic [idx_w(NUM_REGIONS)-1:0]      cfg_idx_i,
  input  pma_region_t                        cfg_region_i,

  // Full table towards the matcher
  output pma_region_t [NUM_REGIONS-1:0]      regions_o
);

  pma_region_t [NUM_REGIONS-1:0] regions_q;
  pma_region_t                   cfg_legal;
  logic                          idx_ok;
  logic                          wr_en;

  // I/O regions are never cacheable
  always_comb begin
    cfg_legal = cfg_region_i;
    if (!cfg_region_i.main) begin
      cfg_legal.cacheable = 1'b0;
    end
  end

  // Out of range indices are dropped for non power of two tables
  assign idx_ok = int'(cfg_idx_i) < NUM_REGIONS;

  // A locked entry ignores writes until reset
  assign wr_en = cfg_we_i && idx_ok && !regions_q[cfg_idx_i].lock;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regions_q <= '0;
    end else if (wr_en) begin
      regions_q[cfg_idx_i] <= cfg_legal;
    end
  end

  assign regions_o = regions_q;

  ////////////////////
  // Assertions
  ////////////////////

  a_num_regions_range :
    assert property (@(posedge clk)
                     (NUM_REGIONS >= 1) && (NUM_REGIONS <= NUM_REGIONS_MAX));

  for (genvar i = 0; i < NUM_REGIONS; i++) begin : g_region_chk
    // Sticky lock, entry frozen from the cycle after it is locked
    a_locked_stable :
      assert property (@(posedge clk) disable iff (!rst_n)
                       regions_q[i].lock |=> $stable(regions_q[i]));

    a_io_not_cacheable :
      assert property (@(posedge clk) disable iff (!rst_n)
                       !regions_q[i].main |-> !regions_q[i].cacheable);
  end

endmodule

/* design/pma_region_match.sv */
// PMA region lookup and fault check
`timescale 1ns/1ps

module pma_region_match import mpu_pkg::*; #(
  parameter int NUM_REGIONS = 4
) (
  input  pma_region_t [NUM_REGIONS-1:0] regions_i,
  input  core_req_t                     core_req_i,
  output logic                          deny_o,
  output bus_req_t                      bus_req_o
);

  localparam int IDX_W = idx_w(NUM_REGIONS);

  logic             hit;
  logic [IDX_W-1:0] hit_idx;
  pma_region_t      sel;

  ////////////////////
  // Lowest match
  ////////////////////

  // Walk downward so the lowest matching index is the last one kept
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = NUM_REGIONS - 1; i >= 0; i--) begin
      if (pma_contains(regions_i[i], core_req_i.addr)) begin
        hit     = 1'b1;
        hit_idx = IDX_W'(i);
      end
    end
  end

  // No match falls back to I/O attributes
  assign sel = hit ? regions_i[hit_idx] : PMA_DEFAULT_ATTR;

  ////////////////////
  // Fault and memtype
  ////////////////////

  // Fetches and misaligned accesses need main memory
  assign deny_o = (core_req_i.instr || core_req_i.misaligned) && !sel.main;

  always_comb begin
    bus_req_o.addr    = core_req_i.addr;
    bus_req_o.we      = core_req_i.we;
    bus_req_o.wdata   = core_req_i.wdata;
    bus_req_o.memtype = '0;
    // Only stores may be buffered
    bus_req_o.memtype[MEMTYPE_BUF_BIT]   = core_req_i.we && sel.bufferable;
    bus_req_o.memtype[MEMTYPE_CACHE_BIT] = sel.cacheable;
  end

  // Selected index must really cover the address
  always_comb begin
    if (hit) begin
      a_sel_contains : assert (pma_contains(regions_i[hit_idx], core_req_i.addr));
    end
  end

endmodule

/* design/mpu_resp_fsm.sv */
// MPU request gating and fault response FSM
`timescale 1ns/1ps

module mpu_resp_fsm import mpu_pkg::*; #(
  parameter int MAX_OUTSTANDING = 2
) (
  input  logic              clk,
  input  logic              rst_n,

  // Core request handshake
  input  logic              core_valid_i,
  output logic              core_ready_o,
  input  logic              deny_i,
  input  bus_req_t          bus_req_i,

  // Bus request channel
  output logic              bus_valid_o,
  input  logic              bus_ready_i,
  output bus_req_t          bus_req_o,

  // Bus response, always taken
  input  logic              bus_resp_valid_i,
  input  logic [DATA_W-1:0] bus_rdata_i,

  // Core response, merged bus and fault
  output logic              core_resp_valid_o,
  output core_resp_t        core_resp_o
);

  localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);

  mpu_state_e       state_q;
  mpu_state_e       state_d;
  logic [CNT_W-1:0] outstanding_q;
  logic             idle;
  logic             room;
  logic             bus_hs;
  logic             deny_hs;
  logic             err_resp;

  assign idle     = (state_q == MPU_IDLE);
  assign room     = outstanding_q < CNT_W'(MAX_OUTSTANDING);
  assign err_resp = (state_q == MPU_ERR_RESP);

  ////////////////////
  // Handshake gating
  ////////////////////

  // Allowed requests pass straight through, denied ones are swallowed
  assign bus_valid_o  = idle && core_valid_i && !deny_i && room;
  assign bus_req_o    = bus_req_i;
  assign core_ready_o = idle && (deny_i || (bus_ready_i && room));

  assign bus_hs  = bus_valid_o && bus_ready_i;
  assign deny_hs = idle && core_valid_i && deny_i;

  // Outstanding bus transactions
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
    end else if (bus_hs && !bus_resp_valid_i) begin
      outstanding_q <= outstanding_q + 1'b1;
    end else if (!bus_hs && bus_resp_valid_i) begin
      outstanding_q <= outstanding_q - 1'b1;
    end
  end

  ////////////////////
  // Fault FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      MPU_IDLE: begin
        if (deny_hs) begin
          state_d = MPU_DRAIN;
        end
      end
      // Fault must wait behind earlier bus responses
      MPU_DRAIN: begin
        if (outstanding_q == '0) begin
          state_d = MPU_ERR_RESP;
        end
      end
      MPU_ERR_RESP: state_d = MPU_IDLE;
      default:      state_d = MPU_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MPU_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Bus and fault responses never overlap, see assertions below
  assign core_resp_valid_o  = bus_resp_valid_i || err_resp;
  assign core_resp_o.rdata  = err_resp ? '0 : bus_rdata_i;
  assign core_resp_o.status = err_resp ? MPU_FAULT : MPU_OK;

  ////////////////////
  // Assertions
  ////////////////////

  a_max_outstanding_range :
    assert property (@(posedge clk)
                     (MAX_OUTSTANDING >= 1) && (MAX_OUTSTANDING <= MAX_OUTSTANDING_MAX));

  a_resp_needs_outstanding :
    assert property (@(posedge clk) disable iff (!rst_n)
                     bus_resp_valid_i |-> (outstanding_q != '0));

  a_no_resp_collision :
    assert property (@(posedge clk) disable iff (!rst_n)
                     !(bus_resp_valid_i && err_resp));

  // Core blocked for the whole drain and fault sequence
  a_block_core :
    assert property (@(posedge clk) disable iff (!rst_n)
                     (state_q != MPU_IDLE) |-> (!core_ready_o && !bus_valid_o));

endmodule

/* design/mpu_top.sv */
// Memory protection unit top level
`timescale 1ns/1ps

module mpu_top import mpu_pkg::*; #(
  parameter int NUM_REGIONS     = 4,
  parameter int MAX_OUTSTANDING = 2
) (
  input  logic                          clk,
  input  logic                          rst_n,

  // Region configuration
  input  logic                          cfg_we_i,
  input  logic [idx_w(NUM_REGIONS)-1:0] cfg_idx_i,
  input  pma_region_t                   cfg_region_i,

  // Core side
  input  logic                          core_valid_i,
  output logic                          core_ready_o,
  input  core_req_t                     core_req_i,
  output logic                          core_resp_valid_o,
  output core_resp_t                    core_resp_o,

  // Bus side
  output logic                          bus_valid_o,
  input  logic                          bus_ready_i,
  output bus_req_t                      bus_req_o,
  input  logic                          bus_resp_valid_i,
  input  logic [DATA_W-1:0]             bus_rdata_i
);

  pma_region_t [NUM_REGIONS-1:0] regions;
  logic                          deny;
  bus_req_t                      match_req;

  pma_region_regs #(
    .NUM_REGIONS (NUM_REGIONS)
  ) i_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_we_i     (cfg_we_i),
    .cfg_idx_i    (cfg_idx_i),
    .cfg_region_i (cfg_region_i),
    .regions_o    (regions)
  );

  pma_region_match #(
    .NUM_REGIONS (NUM_REGIONS)
  ) i_match (
    .regions_i  (regions),
    .core_req_i (core_req_i),
    .deny_o     (deny),
    .bus_req_o  (match_req)
  );

  mpu_resp_fsm #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) i_fsm (
    .clk               (clk),
    .rst_n             (rst_n),
    .core_valid_i      (core_valid_i),
    .core_ready_o      (core_ready_o),
    .deny_i            (deny),
    .bus_req_i         (match_req),
    .bus_valid_o       (bus_valid_o),
    .bus_ready_i       (bus_ready_i),
    .bus_req_o         (bus_req_o),
    .bus_resp_valid_i  (bus_resp_valid_i),
    .bus_rdata_i       (bus_rdata_i),
    .core_resp_valid_o (core_resp_valid_o),
    .core_resp_o       (core_resp_o)
  );

endmodule

/* dv/mpu_tb_model.svh */
// PMA reference model
`ifndef MPU_TB_MODEL_SVH
`define MPU_TB_MODEL_SVH

// Region table as the DUT should hold it
pma_region_t model_tab [N_REG];

function automatic void table_clear();
  foreach (model_tab[i]) begin
    model_tab[i] = '0;
  end
endfunction

// Locked entries keep their old value
// I/O entries are stored without cacheable
function automatic void region_store(input int idx, input pma_region_t r);
  if (!model_tab[idx].lock) begin
    model_tab[idx] = r;
    if (!r.main) begin
      model_tab[idx].cacheable = 1'b0;
    end
  end
endfunction

// Lowest entry whose byte range holds the address
function automatic pma_region_t region_at(input logic [31:0] addr);
  longint lo;
  longint hi;
  for (int i = 0; i < N_REG; i++) begin
    lo = longint'(model_tab[i].word_addr_low) * 4;
    hi = longint'(model_tab[i].word_addr_high) * 4;
    if ((longint'(addr) >= lo) && (longint'(addr) < hi)) begin
      return model_tab[i];
    end
  end
  // Nothing matched so the I/O default applies
  return '0;
endfunction

function automatic logic predict_deny(input core_req_t req);
  pma_region_t r;
  r = region_at(req.addr);
  return (req.instr || req.misaligned) && !r.main;
endfunction

function automatic bus_req_t predict_bus_req(input core_req_t req);
  pma_region_t r;
  bus_req_t    b;
  r       = region_at(req.addr);
  b.addr  = req.addr;
  b.we    = req.we;
  b.wdata = req.wdata;
  // Cacheable in bit 1 and buffered stores in bit 0
  b.memtype = {r.cacheable, req.we & r.bufferable};
  return b;
endfunction

`endif

/* dv/tb_mpu.sv */
// MPU testbench
`timescale 1ns/1ps

module tb_mpu import mpu_pkg::*; ();

  localparam int N_REG     = 4;
  localparam int MAX_OUT   = 2;
  localparam int IDX_BITS  = idx_w(N_REG);
  localparam int TIMEOUT   = 200;
  localparam int N_RANDOM  = 400;
  localparam int READY_PCT = 70;

  // One address per region case of the directed table
  localparam logic [31:0] DIR_ADDR [7] = '{
    32'h0000_1800, 32'h0000_3000, 32'h0000_7800, 32'h0000_8800,
    32'h0000_a000, 32'h0000_c100, 32'h0000_e100
  };

  logic                clk;
  logic                rst_n;
  logic                cfg_we;
  logic [IDX_BITS-1:0] cfg_idx;
  pma_region_t         cfg_region;
  logic                core_valid;
  logic                core_ready;
  core_req_t           core_req;
  logic                core_resp_valid;
  core_resp_t          core_resp;
  logic                bus_valid;
  logic                bus_ready;
  bus_req_t            bus_req;
  logic                bus_resp_valid;
  logic [31:0]         bus_rdata;

  // Expected core responses in acceptance order
  core_resp_t  exp_resp_q [$];
  // Accepted bus requests waiting for their response
  logic [31:0] resp_addr_q [$];
  int          resp_delay_q [$];
  // Fault response is due in the next cycle
  logic        err_due;

  `include "mpu_tb_model.svh"

  mpu_top #(
    .NUM_REGIONS     (N_REG),
    .MAX_OUTSTANDING (MAX_OUT)
  ) i_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .cfg_we_i          (cfg_we),
    .cfg_idx_i         (cfg_idx),
    .cfg_region_i      (cfg_region),
    .core_valid_i      (core_valid),
    .core_ready_o      (core_ready),
    .core_req_i        (core_req),
    .core_resp_valid_o (core_resp_valid),
    .core_resp_o       (core_resp),
    .bus_valid_o       (bus_valid),
    .bus_ready_i       (bus_ready),
    .bus_req_o         (bus_req),
    .bus_resp_valid_i  (bus_resp_valid),
    .bus_rdata_i       (bus_rdata)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "first error at %0t ns", $time);
  endtask

  task automatic flag_compare(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic status_compare(input mpu_status_e got, input mpu_status_e exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL core_resp_o.status got %h expected %h", got, exp));
    end
  endtask

  task automatic core_resp_compare(input core_resp_t got, input core_resp_t exp);
    status_compare(got.status, exp.status);
    if (got !== exp) begin
      abort_run($sformatf("FAIL core_resp_o got %h expected %h", got, exp));
    end
  endtask

  task automatic bus_req_compare(input bus_req_t got, input bus_req_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL bus_req_o got %h expected %h", got, exp));
    end
  endtask

  ////////////////////
  // Stimulus helpers
  ////////////////////

  function automatic pma_region_t region_of(input logic [31:0] lo, input logic [31:0] hi,
                                            input logic main, input logic bufferable,
                                            input logic cacheable, input logic lock);
    pma_region_t r;
    r.word_addr_low  = lo[31:2];
    r.word_addr_high = hi[31:2];
    r.main           = main;
    r.bufferable     = bufferable;
    r.cacheable      = cacheable;
    r.lock           = lock;
    return r;
  endfunction

  // Kind 0 load, 1 store, 2 fetch, 3 misaligned store
  function automatic core_req_t core_req_of(input logic [31:0] addr, input int kind);
    core_req_t r;
    r.addr       = addr;
    r.we         = (kind == 1) || (kind == 3);
    r.wdata      = $urandom;
    r.instr      = (kind == 2);
    r.misaligned = (kind == 3);
    if (kind == 3) begin
      r.addr[0] = 1'b1;
    end
    return r;
  endfunction

  task automatic apply_reset();
    @(posedge clk);
    #2;
    rst_n   = 1'b0;
    err_due = 1'b0;
    table_clear();
    repeat (16) begin
      @(negedge clk);
      if (bus_valid || core_resp_valid) begin
        abort_run("Bus valid or core response active during reset");
      end
    end
    @(posedge clk);
    #2;
    rst_n = 1'b1;
  endtask

  task automatic cfg_write(input int idx, input pma_region_t r);
    @(posedge clk);
    #2;
    cfg_we     = 1'b1;
    cfg_idx    = IDX_BITS'(idx);
    cfg_region = r;
    @(posedge clk);
    region_store(idx, r);
    #2;
    cfg_we = 1'b0;
  endtask

  // Presents a request and returns once it is accepted
  task automatic send_req(input core_req_t req);
    int waited;
    waited = 0;
    @(posedge clk);
    #2;
    core_valid = 1'b1;
    core_req   = req;
    @(negedge clk);
    while (!core_ready) begin
      waited++;
      if (waited > TIMEOUT) begin
        abort_run("Timeout waiting for the core request to be accepted");
      end
      @(negedge clk);
    end
  endtask

  task automatic release_core();
    @(posedge clk);
    #2;
    core_valid = 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_resp_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        abort_run("Timeout waiting for outstanding core responses");
      end
    end
  endtask

  task automatic directed_sweep();
    foreach (DIR_ADDR[i]) begin
      for (int k = 0; k < 4; k++) begin
        send_req(core_req_of(DIR_ADDR[i], k));
      end
    end
    release_core();
    wait_drained();
  endtask

  ////////////////////
  // Bus responder
  ////////////////////

  task automatic drive_bus_side();
    bus_resp_valid = 1'b0;
    bus_rdata      = '0;
    bus_ready      = rst_n && ($urandom_range(99, 0) < READY_PCT);
    if (rst_n && (resp_addr_q.size() != 0)) begin
      if (resp_delay_q[0] > 0) begin
        resp_delay_q[0] = resp_delay_q[0] - 1;
      end else begin
        bus_resp_valid = 1'b1;
        bus_rdata      = ~resp_addr_q.pop_front();
        void'(resp_delay_q.pop_front());
      end
    end
  endtask

  initial begin
    bus_ready      = 1'b0;
    bus_resp_valid = 1'b0;
    bus_rdata      = '0;
    forever begin
      @(posedge clk);
      #2;
      drive_bus_side();
    end
  end

  ////////////////////
  // Scoreboard
  ////////////////////

  // A queued fault means the DUT has left idle
  function automatic logic fault_pending();
    foreach (exp_resp_q[i]) begin
      if (exp_resp_q[i].status == MPU_FAULT) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic observe_cycle();
    bus_req_t   exp_bus;
    core_resp_t exp_resp;
    logic       deny;
    logic       blocked;
    logic       room;
    int         n_out;
    deny    = predict_deny(core_req);
    n_out   = resp_addr_q.size() + int'(bus_resp_valid);
    blocked = fault_pending();
    room    = n_out < MAX_OUT;
    flag_compare("bus_valid_o", bus_valid, !blocked && core_valid && !deny && room);
    if (core_valid) begin
      flag_compare("core_ready_o", core_ready, !blocked && (deny || (bus_ready && room)));
    end
    flag_compare("core_resp_valid_o", core_resp_valid, bus_resp_valid || err_due);
    // Drain ends when nothing is outstanding, the fault follows one cycle later
    err_due = blocked && (n_out == 0) && !err_due;
    if (core_valid && core_ready) begin
      if (deny) begin
        exp_resp.rdata  = '0;
        exp_resp.status = MPU_FAULT;
      end else begin
        exp_bus = predict_bus_req(core_req);
        bus_req_compare(bus_req, exp_bus);
        exp_resp.rdata  = ~core_req.addr;
        exp_resp.status = MPU_OK;
        resp_addr_q.push_back(core_req.addr);
        resp_delay_q.push_back(int'($urandom_range(3, 0)));
      end
      exp_resp_q.push_back(exp_resp);
    end
    if (core_resp_valid) begin
      if (exp_resp_q.size() == 0) begin
        abort_run("Core response with no request outstanding");
      end else begin
        core_resp_compare(core_resp, exp_resp_q.pop_front());
      end
    end
  endtask

  // Outputs are settled half a cycle after the inputs move
  always @(negedge clk) begin
    if (rst_n) begin
      observe_cycle();
    end
  end

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    logic [31:0] addr;
    void'($urandom(54288));
    rst_n      = 1'b0;
    cfg_we     = 1'b0;
    cfg_idx    = '0;
    cfg_region = '0;
    core_valid = 1'b0;
    core_req   = '0;
    apply_reset();

    // Empty table so the fetch must fault
    repeat (4) @(negedge clk);
    send_req(core_req_of(32'h0000_0100, 2));
    release_core();
    wait_drained();

    // Overlapping main regions and one I/O region written as cacheable
    cfg_write(0, region_of(32'h0000_1000, 32'h0000_2000, 1'b1, 1'b0, 1'b1, 1'b0));
    cfg_write(1, region_of(32'h0000_0000, 32'h0000_8000, 1'b1, 1'b1, 1'b0, 1'b0));
    cfg_write(2, region_of(32'h0000_7000, 32'h0000_9000, 1'b0, 1'b1, 1'b1, 1'b0));
    directed_sweep();

    // Second write to a locked entry is dropped
    cfg_write(3, region_of(32'h0000_c000, 32'h0000_d000, 1'b1, 1'b0, 1'b1, 1'b1));
    cfg_write(3, region_of(32'h0000_e000, 32'h0000_f000, 1'b1, 1'b1, 1'b0, 1'b0));
    directed_sweep();

    // Random mix with back-pressure and faults
    for (int n = 0; n < N_RANDOM; n++) begin
      addr = {16'h0000, 4'($urandom_range(15, 0)), 10'($urandom), 2'b00};
      send_req(core_req_of(addr, int'($urandom_range(3, 0))));
      if ($urandom_range(3, 0) == 0) begin
        release_core();
      end
    end
    release_core();
    wait_drained();

    // Lock is cleared by reset
    apply_reset();
    cfg_write(3, region_of(32'h0000_e000, 32'h0000_f000, 1'b1, 1'b1, 1'b0, 1'b0));
    directed_sweep();

    $display("sim passed");
    $finish;
  end

endmodule

/* tb.f */
+incdir+dv
design/mpu_pkg.sv
design/pma_region_regs.sv
design/pma_region_match.sv
design/mpu_resp_fsm.sv
design/mpu_top.sv
dv/tb_mpu.sv

/* run.sh */
#!/bin/sh
# Build and run the MPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f tb.f --top-module tb_mpu -o tb_mpu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_mpu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit 1
fi

exit 0
